// File: Makefile
# Verilator build for rv_pipe
VERILATOR ?= verilator
TOP ?= rv_core_tb
FLIST ?= rv_pipe.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# Pass only if the pass line shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: rv_pipe.f
source/rv_pipe_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_datamem.sv
source/rv_core.sv
sim/rv_core_tb.sv

// File: sim/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

	localparam int N_REAL = 40;		// Random instructions before the dump
	localparam int DUMP_WORD = 899;		// x0 stored here, x31 at 930
	localparam int TIMEOUT = 2000;		// Cycles

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic imem_write = 1'b0;
	logic [rv_pipe_pkg::MEM_AW-1:0] imem_addr = '0;
	rv_pipe_pkg::word_t imem_data = '0;
	logic [3:0] con_write = 4'b0000;
	logic [rv_pipe_pkg::MEM_AW-1:0] con_addr = '0;
	rv_pipe_pkg::word_t con_in = '0;
	rv_pipe_pkg::word_t con_out;

	logic [31:0] rng = 32'hfde66217;
	rv_pipe_pkg::word_t prog [$];
	rv_pipe_pkg::word_t model_reg [32];	// ISA model state
	rv_pipe_pkg::word_t model_mem [rv_pipe_pkg::DMEM_DEPTH];
	int checks = 0;
	int errors = 0;

	rv_core dut0 (.clk(clk), .rst(rst), .imem_write(imem_write), .imem_addr(imem_addr),
		.imem_data(imem_data), .con_write(con_write), .con_addr(con_addr), .con_in(con_in),
		.con_out(con_out));

	initial begin
		forever #4 clk = ~clk;		// 8 ns period
	end

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng = x;
		return x;
	endfunction

	// R and I layout, R passes {funct7, rs2} as the immediate
	function automatic rv_pipe_pkg::word_t pack_fields(logic [11:0] imm, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	// Byte address in words 0 to 31, aligned to the access size
	function automatic logic [11:0] pick_addr(logic [1:0] size, logic [31:0] s);
		logic [1:0] off;
		case (size)
			2'b00: off = s[6:5];
			2'b01: off = {s[6], 1'b0};
			default: off = 2'b00;
		endcase
		return {5'b00000, s[4:0], off};
	endfunction

	//////////////////////////////
	// Program generator
	//////////////////////////////
	task automatic build_program();
		logic [31:0] r;
		logic [31:0] s;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [6:0] opc;
		logic [11:0] imm;
		rv_pipe_pkg::word_t inst;
		for (int n = 0; n < N_REAL; n++) begin
			r = next_rand();
			s = next_rand();
			f3 = r[10:8];
			f7 = (r[11] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0000000;
			case (r[3:0])
				4'd0, 4'd1, 4'd2, 4'd3, 4'd4:
					inst = pack_fields({f7, r[26:22]}, r[21:17], f3, r[16:12],
						rv_pipe_pkg::OPC_OP);
				4'd5, 4'd6, 4'd7, 4'd8: begin
					imm = (f3[1:0] == 2'b01) ? {f7, r[26:22]} : r[31:20];	// Shift or imm
					inst = pack_fields(imm, r[21:17], f3, r[16:12], rv_pipe_pkg::OPC_OPIMM);
				end
				4'd9: inst = {s[31:12], r[16:12], rv_pipe_pkg::OPC_LUI};
				4'd10: inst = {s[31:12], r[16:12], rv_pipe_pkg::OPC_AUIPC};
				4'd11, 4'd12: begin
					if (f3 == 3'b011 || f3[2:1] == 2'b11)
						f3 = 3'b010;		// No such load, lw instead
					inst = pack_fields(pick_addr(f3[1:0], s), 5'd0, f3, r[16:12],
						rv_pipe_pkg::OPC_LOAD);
				end
				4'd13, 4'd14: begin
					f3 = (f3[1:0] == 2'b11) ? 3'b010 : {1'b0, f3[1:0]};
					imm = pick_addr(f3[1:0], s);
					inst = {imm[11:5], r[26:22], 5'd0, f3, imm[4:0], rv_pipe_pkg::OPC_STORE};
				end
				default: begin
					// Branch, jal, system, fence
					case (s[1:0])
						2'b00: opc = 7'b1100011;
						2'b01: opc = 7'b1101111;
						2'b10: opc = 7'b1110011;
						default: opc = 7'b0001111;
					endcase
					inst = {r[31:7], opc};
				end
			endcase
			prog.push_back(inst);
			prog.push_back('0);	// Two no-ops, distance 3
			prog.push_back('0);
		end
		// Register dump, negative offsets off x0 reach the top words
		for (int i = 0; i < 32; i++) begin
			imm = 12'((DUMP_WORD + i) * 4);
			prog.push_back({imm[11:5], 5'(i), 5'd0, 3'b010, imm[4:0], rv_pipe_pkg::OPC_STORE});
		end
		repeat (8)
			prog.push_back('0);	// Tail no-ops
	endtask

	function automatic rv_pipe_pkg::word_t alu_model(logic [2:0] f3, logic alt,
		rv_pipe_pkg::word_t a, rv_pipe_pkg::word_t b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			// Signs differ, negative side is smaller
			3'b010: return (a[31] != b[31]) ? {31'b0, a[31]} : ((a < b) ? 32'd1 : 32'd0);
			3'b011: return (a < b) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b101: return alt ? (a >> b[4:0]) | (a[31] ? ~(32'hffffffff >> b[4:0]) : 32'd0)
				: a >> b[4:0];	// Sign bits fill the vacated top
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	//////////////////////////////
	// ISA model, one instruction at a time
	//////////////////////////////
	task automatic run_model();
		rv_pipe_pkg::word_t inst, a, b, imm_i, imm_s, res, w;
		logic [11:0] ea;
		logic wr;
		for (int k = 0; k < prog.size(); k++) begin
			inst = prog[k];
			a = model_reg[inst[19:15]];
			b = model_reg[inst[24:20]];
			imm_i = {{20{inst[31]}}, inst[31:20]};
			imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			wr = 1'b1;
			res = '0;
			case (inst[6:0])
				rv_pipe_pkg::OPC_LUI: res = {inst[31:12], 12'b0};
				rv_pipe_pkg::OPC_AUIPC: res = {inst[31:12], 12'b0} + 32'(4 * k);	// Own address
				rv_pipe_pkg::OPC_OP: res = alu_model(inst[14:12], inst[30], a, b);
				rv_pipe_pkg::OPC_OPIMM:
					res = alu_model(inst[14:12], inst[30] && inst[14:12] == 3'b101, a, imm_i);
				rv_pipe_pkg::OPC_LOAD: begin
					ea = a[11:0] + imm_i[11:0];
					w = model_mem[ea[11:2]] >> (8 * ea[1:0]);
					case (inst[14:12])
						3'b000: res = {{24{w[7]}}, w[7:0]};
						3'b001: res = {{16{w[15]}}, w[15:0]};
						3'b100: res = {24'b0, w[7:0]};
						3'b101: res = {16'b0, w[15:0]};
						default: res = w;
					endcase
				end
				rv_pipe_pkg::OPC_STORE: begin
					wr = 1'b0;
					ea = a[11:0] + imm_s[11:0];
					w = model_mem[ea[11:2]];
					case (inst[13:12])
						2'b00: w[8 * ea[1:0] +: 8] = b[7:0];
						2'b01: w[8 * ea[1:0] +: 16] = b[15:0];
						default: w = b;
					endcase
					model_mem[ea[11:2]] = w;
				end
				default: wr = 1'b0;	// Unknown, no effect
			endcase
			if (wr && inst[11:7] != 5'd0)
				model_reg[inst[11:7]] = res;
		end
	endtask

	//////////////////////////////
	// Port access and checks
	//////////////////////////////
	task automatic write_data_word(int addr, logic [3:0] be, rv_pipe_pkg::word_t data);
		@(posedge clk);
		#1;
		con_write = be;
		con_addr = 10'(addr);
		con_in = data;
		@(posedge clk);
		#1;
		con_write = 4'b0000;
	endtask

	task automatic read_data_word(int addr, output rv_pipe_pkg::word_t data);
		@(posedge clk);
		#1;
		con_addr = 10'(addr);
		@(posedge clk);
		#1;
		data = con_out;		// Registered read, one cycle
	endtask

	task automatic check_mem_word(int addr, rv_pipe_pkg::word_t exp, rv_pipe_pkg::word_t got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED t=%0t word %0d expected %h got %h", $time, addr, exp, got);
		end
	endtask

	task automatic check_range(string name, int first, int last);
		rv_pipe_pkg::word_t got;
		int errs_before;
		errs_before = errors;
		for (int a = first; a <= last; a++) begin
			read_data_word(a, got);
			check_mem_word(a, model_mem[a], got);
		end
		$display("test %s: %0d words, %0d errors", name, last - first + 1,
			errors - errs_before);
	endtask

	initial begin
		rv_pipe_pkg::word_t v;
		logic [31:0] r;
		int cycles;
		for (int i = 0; i < 32; i++)
			model_reg[i] = '0;
		for (int i = 0; i < rv_pipe_pkg::DMEM_DEPTH; i++)
			model_mem[i] = '0;
		build_program();
		foreach (prog[i]) begin
			@(posedge clk);
			#1;
			imem_write = 1'b1;	// One word per cycle, rst still high
			imem_addr = 10'(i);
			imem_data = prog[i];
		end
		@(posedge clk);
		#1;
		imem_write = 1'b0;
		for (int i = 0; i < 64; i++) begin
			v = next_rand();
			write_data_word(i, 4'b1111, v);
			model_mem[i] = v;
		end
		// Partial byte enables on words the program never touches
		for (int i = 32; i < 48; i++) begin
			v = next_rand();
			r = next_rand();
			write_data_word(i, r[3:0], v);
			for (int b = 0; b < 4; b++)
				if (r[b])
					model_mem[i][8 * b +: 8] = v[8 * b +: 8];
		end
		check_range("controller port", 0, 63);
		run_model();
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		cycles = 0;
		while (dut0.if_pc < 12'(4 * prog.size()) && cycles < TIMEOUT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (cycles >= TIMEOUT) begin
			$display("Timeout: PC never got past the end of the program");
			$display("CHECKS FAILED");
		end else begin
			rst = 1'b1;		// Freeze the pipeline
			check_range("register dump", DUMP_WORD, DUMP_WORD + 31);
			check_range("load and store words", 0, 31);
			check_range("untouched words", 32, 63);
			$display("total %0d checks, %0d errors", checks, errors);
			if (errors == 0)
				$display("ALL CHECKS PASSED");
			else
				$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: source/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
	input rv_pipe_pkg::word_t op_a,
	input rv_pipe_pkg::word_t op_b,
	input rv_pipe_pkg::alu_op_t alu_op,
	output rv_pipe_pkg::word_t res,
	output logic z,				// Result is zero
	output logic less			// Signed a < b
);

	logic [4:0] shamt;

	assign shamt = op_b[4:0];		// Low 5 bits only

	always_comb begin
		case (alu_op)
			rv_pipe_pkg::ALU_ADD: res = op_a + op_b;
			rv_pipe_pkg::ALU_SUB: res = op_a - op_b;
			rv_pipe_pkg::ALU_SLL: res = op_a << shamt;
			rv_pipe_pkg::ALU_SLT: res = {31'b0, $signed(op_a) < $signed(op_b)};
			rv_pipe_pkg::ALU_SLTU: res = {31'b0, op_a < op_b};
			rv_pipe_pkg::ALU_XOR: res = op_a ^ op_b;
			rv_pipe_pkg::ALU_SRL: res = op_a >> shamt;
			rv_pipe_pkg::ALU_SRA: res = $unsigned($signed(op_a) >>> shamt);
			rv_pipe_pkg::ALU_OR: res = op_a | op_b;
			rv_pipe_pkg::ALU_AND: res = op_a & op_b;
			rv_pipe_pkg::ALU_PASSB: res = op_b;
			default: res = '0;
		endcase
	end

	// Flags for a later branch unit
	assign z = (res == '0);
	assign less = $signed(op_a) < $signed(op_b);

endmodule

`default_nettype wire

// File: source/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
	input logic clk,
	input logic rst,

	// Instruction load port
	input logic imem_write,
	input logic [rv_pipe_pkg::MEM_AW-1:0] imem_addr,
	input rv_pipe_pkg::word_t imem_data,

	// Protocol controller port to data memory
	input logic [3:0] con_write,
	input logic [rv_pipe_pkg::MEM_AW-1:0] con_addr,
	input rv_pipe_pkg::word_t con_in,
	output rv_pipe_pkg::word_t con_out
);

	//////////////////////////////
	// IF stage
	//////////////////////////////
	rv_pipe_pkg::pc_t if_pc;
	rv_pipe_pkg::word_t imem [rv_pipe_pkg::IMEM_DEPTH];
	rv_pipe_pkg::word_t id_inst;		// IF/ID
	rv_pipe_pkg::pc_t id_pc;

	always_ff @(posedge clk) begin
		if (rst)
			if_pc <= '0;
		else
			if_pc <= if_pc + 12'd4;	// No branches, always PC + 4
	end

	always_ff @(posedge clk) begin
		if (imem_write)
			imem[imem_addr] <= imem_data;	// Works during rst
	end

	always_ff @(posedge clk) begin
		id_inst <= rst ? '0 : imem[if_pc[11:2]];	// Zero word is a no-op
		id_pc <= if_pc;
	end

	//////////////////////////////
	// ID stage
	//////////////////////////////
	rv_pipe_pkg::alu_op_t id_alu_op, exe_alu_op;
	logic id_sel_op_a, id_sel_op_b, exe_sel_op_a, exe_sel_op_b;
	logic id_wr_en, exe_wr_en, mem_wr_en, wb_wr_en;
	logic id_is_store, exe_is_store, mem_is_store;
	rv_pipe_pkg::mem_size_t id_mem_size, exe_mem_size, mem_mem_size;
	rv_pipe_pkg::wb_sel_t id_sel_data, exe_sel_data, mem_sel_data, wb_sel_data;
	rv_pipe_pkg::word_t id_imm, exe_imm, mem_imm, wb_imm;
	rv_pipe_pkg::word_t id_rs1, id_rs2, exe_rs1, exe_rs2, mem_rs2;
	rv_pipe_pkg::reg_addr_t exe_rd, mem_rd, wb_rd;
	rv_pipe_pkg::pc_t exe_pc, mem_pc, wb_pc;
	rv_pipe_pkg::word_t wb_wr_data;

	rv_decoder decoder0 (.inst(id_inst), .alu_op(id_alu_op), .sel_op_a(id_sel_op_a),
		.sel_op_b(id_sel_op_b), .wr_en(id_wr_en), .is_store(id_is_store),
		.mem_size(id_mem_size), .sel_data(id_sel_data), .imm(id_imm));

	rv_regfile regfile0 (.clk(clk), .rst(rst), .wr_en(wb_wr_en), .dest_addr(wb_rd),
		.wr_data(wb_wr_data), .src1_addr(id_inst[19:15]), .src2_addr(id_inst[24:20]),
		.src1_out(id_rs1), .src2_out(id_rs2));

	// ID/EXE, only the strobes take reset
	always_ff @(posedge clk) begin
		exe_wr_en <= rst ? 1'b0 : id_wr_en;
		exe_is_store <= rst ? 1'b0 : id_is_store;
		exe_alu_op <= id_alu_op;
		exe_sel_op_a <= id_sel_op_a;
		exe_sel_op_b <= id_sel_op_b;
		exe_mem_size <= id_mem_size;
		exe_sel_data <= id_sel_data;
		exe_imm <= id_imm;
		exe_rs1 <= id_rs1;
		exe_rs2 <= id_rs2;
		exe_rd <= id_inst[11:7];
		exe_pc <= id_pc;
	end

	//////////////////////////////
	// EXE stage
	//////////////////////////////
	rv_pipe_pkg::word_t op_a, op_b, exe_alu_out, mem_alu_out, wb_alu_out;
	rv_pipe_pkg::word_t mem_load, wb_load;

	assign op_a = exe_sel_op_a ? exe_rs1 : {20'b0, exe_pc};	// PC for AUIPC
	assign op_b = exe_sel_op_b ? exe_imm : exe_rs2;

	// Flags unused until branches exist
	rv_alu alu0 (.op_a(op_a), .op_b(op_b), .alu_op(exe_alu_op), .res(exe_alu_out),
		.z(), .less());

	always_ff @(posedge clk) begin
		mem_wr_en <= rst ? 1'b0 : exe_wr_en;
		mem_is_store <= rst ? 1'b0 : exe_is_store;
		mem_alu_out <= exe_alu_out;
		mem_rs2 <= exe_rs2;
		mem_imm <= exe_imm;
		mem_rd <= exe_rd;
		mem_pc <= exe_pc;
		mem_mem_size <= exe_mem_size;
		mem_sel_data <= exe_sel_data;
	end

	//////////////////////////////
	// MEM stage
	//////////////////////////////
	rv_datamem datamem0 (.clk(clk), .store(mem_is_store), .mem_size(mem_mem_size),
		.addr(mem_alu_out[11:0]), .store_data(mem_rs2), .load_data(mem_load),
		.con_write(con_write), .con_addr(con_addr), .con_in(con_in), .con_out(con_out));

	always_ff @(posedge clk) begin
		wb_wr_en <= rst ? 1'b0 : mem_wr_en;
		wb_alu_out <= mem_alu_out;
		wb_load <= mem_load;
		wb_imm <= mem_imm;
		wb_rd <= mem_rd;
		wb_pc <= mem_pc;
		wb_sel_data <= mem_sel_data;
	end

	//////////////////////////////
	// WB stage
	//////////////////////////////
	always_comb begin
		case (wb_sel_data)
			rv_pipe_pkg::WB_PC4: wb_wr_data = {20'b0, wb_pc + 12'd4};
			rv_pipe_pkg::WB_ALU: wb_wr_data = wb_alu_out;
			rv_pipe_pkg::WB_IMM: wb_wr_data = wb_imm;
			default: wb_wr_data = wb_load;	// WB_LOAD
		endcase
	end

	// Whole pipeline drained of strobes on the first cycle out of reset
	assert property (@(posedge clk) $fell(rst) |=>
		!(exe_wr_en || mem_wr_en || wb_wr_en || exe_is_store || mem_is_store))
		else $error("Write strobe set right after reset");

endmodule

`default_nettype wire

// File: source/rv_datamem.sv
`timescale 1ns/1ps
`default_nettype none

module rv_datamem (
	input logic clk,
	input logic store,			// Core store strobe
	input rv_pipe_pkg::mem_size_t mem_size,
	input rv_pipe_pkg::pc_t addr,		// Byte address
	input rv_pipe_pkg::word_t store_data,	// rs2, unaligned
	output rv_pipe_pkg::word_t load_data,

	// Protocol controller port
	input logic [3:0] con_write,		// Byte enables
	input logic [rv_pipe_pkg::MEM_AW-1:0] con_addr,
	input rv_pipe_pkg::word_t con_in,
	output rv_pipe_pkg::word_t con_out
);

	rv_pipe_pkg::word_t mem [rv_pipe_pkg::DMEM_DEPTH];

	logic [rv_pipe_pkg::MEM_AW-1:0] word_addr;
	logic [1:0] byte_off;
	logic [3:0] lane_mask;			// Size mask before shift
	logic [3:0] core_be;
	rv_pipe_pkg::word_t lane_data;		// Store data in its byte lanes
	rv_pipe_pkg::word_t rd_word;
	rv_pipe_pkg::word_t shifted;		// Addressed bytes moved to bit 0

	assign word_addr = addr[11:2];
	assign byte_off = addr[1:0];

	//////////////////////////////
	// Store alignment
	//////////////////////////////
	always_comb begin
		case (mem_size)
			rv_pipe_pkg::MEM_B: lane_mask = 4'b0001;
			rv_pipe_pkg::MEM_H: lane_mask = 4'b0011;
			default: lane_mask = 4'b1111;
		endcase
		core_be = store ? (lane_mask << byte_off) : 4'b0000;
	end

	assign lane_data = store_data << {byte_off, 3'b000};

	// Core write after controller write, core wins a shared byte
	always_ff @(posedge clk) begin
		for (int b = 0; b < 4; b++) begin
			if (con_write[b])
				mem[con_addr][8*b +: 8] <= con_in[8*b +: 8];
			if (core_be[b])
				mem[word_addr][8*b +: 8] <= lane_data[8*b +: 8];
		end
		con_out <= mem[con_addr];	// Registered, one cycle latency
	end

	//////////////////////////////
	// Load extraction
	//////////////////////////////
	assign rd_word = mem[word_addr];	// Combinational read
	assign shifted = rd_word >> {byte_off, 3'b000};

	always_comb begin
		case (mem_size)
			rv_pipe_pkg::MEM_B: load_data = {{24{shifted[7]}}, shifted[7:0]};
			rv_pipe_pkg::MEM_H: load_data = {{16{shifted[15]}}, shifted[15:0]};
			rv_pipe_pkg::MEM_BU: load_data = {24'b0, shifted[7:0]};
			rv_pipe_pkg::MEM_HU: load_data = {16'b0, shifted[15:0]};
			rv_pipe_pkg::MEM_W: load_data = rd_word;
			default: load_data = rd_word;
		endcase
	end

	// Decoder gives byte size to non-memory ops, so this holds every cycle
	assert property (@(posedge clk) (mem_size[1:0] == 2'b01) |-> (addr[0] == 1'b0))
		else $error("Half access at odd address %h", addr);
	assert property (@(posedge clk) (mem_size[1:0] == 2'b10) |-> (addr[1:0] == 2'b00))
		else $error("Word access at offset %h", addr);

endmodule

`default_nettype wire

// File: source/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
	input rv_pipe_pkg::word_t inst,
	output rv_pipe_pkg::alu_op_t alu_op,
	output logic sel_op_a,			// 1 rs1, 0 PC
	output logic sel_op_b,			// 1 immediate, 0 rs2
	output logic wr_en,
	output logic is_store,
	output rv_pipe_pkg::mem_size_t mem_size,
	output rv_pipe_pkg::wb_sel_t sel_data,
	output rv_pipe_pkg::word_t imm
);

	rv_pipe_pkg::imm_sel_t imm_sel;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic alt;				// funct7 bit 5, sub and sra

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign alt = inst[30];

	// funct3 to ALU operation, shared by OP and OP-IMM
	function automatic rv_pipe_pkg::alu_op_t funct_op(input logic [2:0] f3, input logic sub_sra);
		case (f3)
			3'b000: funct_op = sub_sra ? rv_pipe_pkg::ALU_SUB : rv_pipe_pkg::ALU_ADD;
			3'b001: funct_op = rv_pipe_pkg::ALU_SLL;
			3'b010: funct_op = rv_pipe_pkg::ALU_SLT;
			3'b011: funct_op = rv_pipe_pkg::ALU_SLTU;
			3'b100: funct_op = rv_pipe_pkg::ALU_XOR;
			3'b101: funct_op = sub_sra ? rv_pipe_pkg::ALU_SRA : rv_pipe_pkg::ALU_SRL;
			3'b110: funct_op = rv_pipe_pkg::ALU_OR;
			default: funct_op = rv_pipe_pkg::ALU_AND;
		endcase
	endfunction

	//////////////////////////////
	// Control unit
	//////////////////////////////
	always_comb begin
		// Defaults give a no-op
		alu_op = rv_pipe_pkg::ALU_ADD;
		sel_op_a = 1'b1;
		sel_op_b = 1'b1;
		wr_en = 1'b0;
		is_store = 1'b0;
		mem_size = rv_pipe_pkg::MEM_B;	// Byte is never misaligned
		sel_data = rv_pipe_pkg::WB_ALU;
		imm_sel = rv_pipe_pkg::IMM_I;
		case (opcode)
			rv_pipe_pkg::OPC_LUI: begin
				alu_op = rv_pipe_pkg::ALU_PASSB;
				imm_sel = rv_pipe_pkg::IMM_U;
				sel_data = rv_pipe_pkg::WB_IMM;
				wr_en = 1'b1;
			end
			rv_pipe_pkg::OPC_AUIPC: begin
				sel_op_a = 1'b0;	// PC + upper immediate
				imm_sel = rv_pipe_pkg::IMM_U;
				wr_en = 1'b1;
			end
			rv_pipe_pkg::OPC_OP: begin
				alu_op = funct_op(funct3, alt);
				sel_op_b = 1'b0;
				wr_en = 1'b1;
			end
			rv_pipe_pkg::OPC_OPIMM: begin
				// Only srai uses bit 30, addi has no subtract form
				alu_op = funct_op(funct3, alt && (funct3 == 3'b101));
				wr_en = 1'b1;
			end
			rv_pipe_pkg::OPC_LOAD: begin
				mem_size = funct3;
				sel_data = rv_pipe_pkg::WB_LOAD;
				wr_en = 1'b1;
			end
			rv_pipe_pkg::OPC_STORE: begin
				mem_size = funct3;
				imm_sel = rv_pipe_pkg::IMM_S;
				is_store = 1'b1;
			end
			default: ;			// Unknown opcode retires as no-op
		endcase
	end

	//////////////////////////////
	// Immediate shift, sign extend and shuffle
	//////////////////////////////
	always_comb begin
		case (imm_sel)
			rv_pipe_pkg::IMM_S: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			rv_pipe_pkg::IMM_U: imm = {inst[31:12], 12'b0};
			default: imm = {{20{inst[31]}}, inst[31:20]};	// I-type
		endcase
	end

endmodule

`default_nettype wire

// File: source/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

	//////////////////////////////
	// Widths and depths
	//////////////////////////////
	typedef logic [31:0] word_t;		// Data word
	typedef logic [11:0] pc_t;		// Byte address, instr and data
	typedef logic [4:0] reg_addr_t;		// Register index

	localparam int IMEM_DEPTH = 1024;	// Words
	localparam int DMEM_DEPTH = 1024;	// Words
	localparam int MEM_AW = 10;		// Word address width of both memories

	//////////////////////////////
	// Opcodes
	//////////////////////////////
	localparam logic [6:0] OPC_LUI   = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_OP    = 7'b0110011;
	localparam logic [6:0] OPC_OPIMM = 7'b0010011;
	localparam logic [6:0] OPC_LOAD  = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;

	//////////////////////////////
	// Control encodings
	//////////////////////////////
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
		ALU_PASSB		// Operand B straight through, LUI
	} alu_op_t;

	// Immediate format
	typedef enum logic [2:0] {IMM_I, IMM_S, IMM_U} imm_sel_t;

	// Access size, same bits as funct3 of loads and stores
	typedef logic [2:0] mem_size_t;
	localparam mem_size_t MEM_B  = 3'b000;
	localparam mem_size_t MEM_H  = 3'b001;
	localparam mem_size_t MEM_W  = 3'b010;
	localparam mem_size_t MEM_BU = 3'b100;
	localparam mem_size_t MEM_HU = 3'b101;

	// Writeback source
	typedef enum logic [1:0] {
		WB_PC4,		// Link value, kept for jumps
		WB_ALU,
		WB_IMM,
		WB_LOAD
	} wb_sel_t;

endpackage

`default_nettype wire

// File: source/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
	input logic clk,
	input logic rst,
	input logic wr_en,
	input rv_pipe_pkg::reg_addr_t dest_addr,
	input rv_pipe_pkg::word_t wr_data,
	input rv_pipe_pkg::reg_addr_t src1_addr,
	input rv_pipe_pkg::reg_addr_t src2_addr,
	output rv_pipe_pkg::word_t src1_out,
	output rv_pipe_pkg::word_t src2_out
);

	rv_pipe_pkg::word_t regs [32];
	logic wr_live;				// Real write, never x0

	assign wr_live = wr_en && (dest_addr != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_live) begin
			regs[dest_addr] <= wr_data;
		end
	end

	// Write-through, WB result visible to ID in the same cycle
	assign src1_out = (wr_live && dest_addr == src1_addr) ? wr_data : regs[src1_addr];
	assign src2_out = (wr_live && dest_addr == src2_addr) ? wr_data : regs[src2_addr];

	// x0 stays zero over time, only reset ever writes it
	assert property (@(posedge clk) disable iff (rst)
		(src1_addr == '0) |-> (src1_out == '0))
		else $error("x0 read nonzero");

endmodule

`default_nettype wire
